// File: filelist.f
+incdir+logic
+incdir+tests
logic/rv_isa_pkg.sv
logic/predecode_pkg.sv
logic/fetch_capture.sv
logic/c_expander.sv
logic/rv32_legality_check.sv
logic/decode_result_reg.sv
logic/rv_predecode_top.sv
tests/tb_rv_predecode.sv

// File: logic/c_expander.sv
////////////////////////////////////////
// compressed to RV32I expansion with
// reserved encoding detection
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "rv_decode_consts.svh"

module c_expander (
  input  wire predecode_pkg::fetch_word_t fetch_i,
  output predecode_pkg::expand_t          exp_o
);

  rv_isa_pkg::cinstr_t   c;
  rv_isa_pkg::quadrant_t quad;
  rv_isa_pkg::funct3_t   c_funct3;
  rv_isa_pkg::reg_idx_t  rd;
  rv_isa_pkg::reg_idx_t  rs2;
  rv_isa_pkg::reg_idx_t  rs1_p;
  rv_isa_pkg::reg_idx_t  rd_p;
  rv_isa_pkg::funct3_t   alu_f3;
  rv_isa_pkg::funct7_t   alu_f7;

  assign c        = fetch_i.instr[`RV_CINSTR_W-1:0];
  assign quad     = c[1:0];
  assign c_funct3 = c[15:13];
  assign rd       = c[11:7];
  assign rs2      = c[6:2];
  // primed registers map onto x8..x15
  assign rs1_p    = {2'b01, c[9:7]};
  assign rd_p     = {2'b01, c[4:2]};

  always_comb begin
    exp_o.instr         = fetch_i.instr;
    exp_o.is_compressed = (quad != 2'b11);
    exp_o.illegal       = 1'b0;
    alu_f3              = 3'b000;
    alu_f7              = 7'b0;

    case (quad)
      ////////////////////////////////////////
      // quadrant 0
      2'b00: begin
        case (c_funct3)
          3'b000: begin
            // c.addi4spn, zero immediate is reserved
            exp_o.instr = {2'b0, c[10:7], c[12:11], c[5], c[6], 2'b00, `RV_REG_SP,
                           3'b000, rd_p, `RV_OPCODE_OPIMM};
            exp_o.illegal = (c[12:5] == 8'b0);
          end
          3'b010: begin
            // c.lw
            exp_o.instr = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1_p, 3'b010, rd_p,
                           `RV_OPCODE_LOAD};
          end
          3'b110: begin
            // c.sw
            exp_o.instr = {5'b0, c[5], c[12], rd_p, rs1_p, 3'b010, c[11:10], c[6], 2'b00,
                           `RV_OPCODE_STORE};
          end
          default: begin
            // float load/store and reserved slot
            exp_o.illegal = 1'b1;
          end
        endcase
      end

      ////////////////////////////////////////
      // quadrant 1
      2'b01: begin
        case (c_funct3)
          3'b000: begin
            // c.addi and c.nop
            exp_o.instr = {{6{c[12]}}, c[12], c[6:2], rd, 3'b000, rd, `RV_OPCODE_OPIMM};
          end
          3'b001, 3'b101: begin
            // c.jal links to x1, c.j to x0
            exp_o.instr = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                           {9{c[12]}}, 4'b0, ~c[15], `RV_OPCODE_JAL};
          end
          3'b010: begin
            // c.li, rd of x0 is a hint
            exp_o.instr = {{6{c[12]}}, c[12], c[6:2], 5'b0, 3'b000, rd, `RV_OPCODE_OPIMM};
          end
          3'b011: begin
            if ({c[12], c[6:2]} == 6'b0) begin
              exp_o.illegal = 1'b1;
            end else if (rd == `RV_REG_SP) begin
              // c.addi16sp
              exp_o.instr = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0, `RV_REG_SP,
                             3'b000, `RV_REG_SP, `RV_OPCODE_OPIMM};
            end else begin
              // c.lui, rd of x0 is a hint
              exp_o.instr = {{15{c[12]}}, c[6:2], rd, `RV_OPCODE_LUI};
            end
          end
          3'b100: begin
            case (c[11:10])
              2'b00, 2'b01: begin
                // c.srli / c.srai, shamt[5] set is reserved on RV32
                exp_o.instr = {1'b0, c[10], 5'b0, c[6:2], rs1_p, 3'b101, rs1_p,
                               `RV_OPCODE_OPIMM};
                exp_o.illegal = c[12];
              end
              2'b10: begin
                // c.andi
                exp_o.instr = {{6{c[12]}}, c[12], c[6:2], rs1_p, 3'b111, rs1_p,
                               `RV_OPCODE_OPIMM};
              end
              default: begin
                // register ALU group
                case ({c[12], c[6:5]})
                  3'b000: begin
                    alu_f3 = 3'b000;
                    alu_f7 = 7'b010_0000;
                  end
                  3'b001: alu_f3 = 3'b100;
                  3'b010: alu_f3 = 3'b110;
                  3'b011: alu_f3 = 3'b111;
                  // subw, addw and reserved
                  default: exp_o.illegal = 1'b1;
                endcase
                exp_o.instr = {alu_f7, rd_p, rs1_p, alu_f3, rs1_p, `RV_OPCODE_OP};
              end
            endcase
          end
          default: begin
            // c.beqz / c.bnez, funct3 bit 0 from c[13]
            exp_o.instr = {{4{c[12]}}, c[6:5], c[2], 5'b0, rs1_p, 2'b00, c[13], c[11:10],
                           c[4:3], c[12], `RV_OPCODE_BRANCH};
          end
        endcase
      end

      ////////////////////////////////////////
      // quadrant 2
      2'b10: begin
        case (c_funct3)
          3'b000: begin
            // c.slli, zero shamt or rd x0 are hints
            exp_o.instr   = {7'b0, c[6:2], rd, 3'b001, rd, `RV_OPCODE_OPIMM};
            exp_o.illegal = c[12];
          end
          3'b010: begin
            // c.lwsp, rd x0 reserved
            exp_o.instr = {4'b0, c[3:2], c[12], c[6:4], 2'b00, `RV_REG_SP, 3'b010, rd,
                           `RV_OPCODE_LOAD};
            exp_o.illegal = (rd == 5'd0);
          end
          3'b100: begin
            if (!c[12]) begin
              if (rs2 == 5'd0) begin
                // c.jr, rs1 x0 reserved
                exp_o.instr   = {12'b0, rd, 3'b000, 5'd0, `RV_OPCODE_JALR};
                exp_o.illegal = (rd == 5'd0);
              end else begin
                // c.mv
                exp_o.instr = {7'b0, rs2, 5'd0, 3'b000, rd, `RV_OPCODE_OP};
              end
            end else if (rs2 == 5'd0) begin
              if (rd == 5'd0) begin
                exp_o.instr = `RV_EBREAK_WORD;
              end else begin
                // c.jalr links to x1
                exp_o.instr = {12'b0, rd, 3'b000, 5'd1, `RV_OPCODE_JALR};
              end
            end else begin
              // c.add
              exp_o.instr = {7'b0, rs2, rd, 3'b000, rd, `RV_OPCODE_OP};
            end
          end
          3'b110: begin
            // c.swsp
            exp_o.instr = {4'b0, c[8:7], c[12], rs2, `RV_REG_SP, 3'b010, c[11:9], 2'b00,
                           `RV_OPCODE_STORE};
          end
          default: begin
            // sp-relative float forms
            exp_o.illegal = 1'b1;
          end
        endcase
      end

      // 32-bit word passes through
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/decode_result_reg.sv
////////////////////////////////////////
// output register for the decode result
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module decode_result_reg (
  input  wire logic                      clk_i,
  input  wire logic                      rst_n_i,
  input  wire logic                      valid_i,
  input  wire predecode_pkg::expand_t    exp_i,
  input  wire logic                      illegal_i,
  input  wire logic                      rs1_used_i,
  input  wire logic                      rs2_used_i,
  output predecode_pkg::decode_result_t  result_o,
  output logic                           result_valid_o
);

  // result is held between strobes, only the valid bit pulses
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      result_valid_o <= 1'b0;
      result_o       <= '0;
    end else begin
      result_valid_o <= valid_i;
      if (valid_i) begin
        result_o.instr         <= exp_i.instr;
        result_o.is_compressed <= exp_i.is_compressed;
        result_o.illegal       <= illegal_i;
        result_o.rs1_used      <= rs1_used_i;
        result_o.rs2_used      <= rs2_used_i;
      end
    end
  end

  // checker must report illegal words as reading both ports
  a_illegal_uses: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    result_o.illegal |-> (result_o.rs1_used && result_o.rs2_used)
  );

endmodule

`default_nettype wire

// File: logic/fetch_capture.sv
////////////////////////////////////////
// input register for the fetched word
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module fetch_capture (
  input  wire logic                      clk_i,
  input  wire logic                      rst_n_i,
  input  wire logic                      instr_valid_i,
  input  wire rv_isa_pkg::instr_t        instr_i,
  input  wire logic                      debug_mode_i,
  output predecode_pkg::fetch_word_t     fetch_o
);

  // valid strobe, follows the input every cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fetch_o.valid <= 1'b0;
    end else begin
      fetch_o.valid <= instr_valid_i;
    end
  end

  // word and debug level are taken at the same edge
  // so a later dret check sees the mode of its own instruction
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      fetch_o.instr      <= instr_i;
      fetch_o.debug_mode <= debug_mode_i;
    end
  end

  // a strobed fetch must leave a fully known word in the register
  a_fetch_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    instr_valid_i |=> !$isunknown(fetch_o.instr)
  );

endmodule

`default_nettype wire

// File: logic/predecode_pkg.sv
////////////////////////////////////////
// structs passed between the fetch, expand
// and result stages
////////////////////////////////////////
`default_nettype none

package predecode_pkg;

  // captured fetch word, 34 bits
  typedef struct packed {
    logic               valid;
    logic               debug_mode;
    rv_isa_pkg::instr_t instr;
  } fetch_word_t;

  // expander output, 34 bits
  typedef struct packed {
    rv_isa_pkg::instr_t instr;
    logic               is_compressed;
    logic               illegal;
  } expand_t;

  // final decode result, 36 bits
  typedef struct packed {
    rv_isa_pkg::instr_t instr;
    logic               is_compressed;
    logic               illegal;
    logic               rs1_used;
    logic               rs2_used;
  } decode_result_t;

endpackage

`default_nettype wire

// File: logic/rv32_legality_check.sv
////////////////////////////////////////
// RV32I legality and source register use
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "rv_decode_consts.svh"

module rv32_legality_check (
  input  wire predecode_pkg::expand_t exp_i,
  input  wire logic                   debug_mode_i,
  output logic                        illegal_o,
  output logic                        rs1_used_o,
  output logic                        rs2_used_o
);

  rv_isa_pkg::opcode_t  opcode;
  rv_isa_pkg::funct3_t  funct3;
  rv_isa_pkg::funct7_t  funct7;
  rv_isa_pkg::reg_idx_t rs1;
  rv_isa_pkg::reg_idx_t rd;
  logic [11:0]          funct12;
  logic                 bad;
  logic                 rs1_en;
  logic                 rs2_en;

  assign opcode  = exp_i.instr[6:0];
  assign rd      = exp_i.instr[11:7];
  assign funct3  = exp_i.instr[14:12];
  assign rs1     = exp_i.instr[19:15];
  assign funct7  = exp_i.instr[31:25];
  assign funct12 = exp_i.instr[31:20];

  always_comb begin
    bad    = 1'b0;
    rs1_en = 1'b0;
    rs2_en = 1'b0;

    case (opcode)
      `RV_OPCODE_JAL, `RV_OPCODE_LUI, `RV_OPCODE_AUIPC: begin
        // no source registers
      end
      `RV_OPCODE_JALR: begin
        rs1_en = 1'b1;
        bad    = (funct3 != 3'b000);
      end
      `RV_OPCODE_LOAD: begin
        rs1_en = 1'b1;
        // ld, lwu and reserved
        bad    = (funct3 inside {3'b011, 3'b110, 3'b111});
      end
      `RV_OPCODE_BRANCH, `RV_OPCODE_STORE: begin
        rs1_en = 1'b1;
        rs2_en = 1'b1;
      end
      `RV_OPCODE_OPIMM: begin
        rs1_en = 1'b1;
        if (funct3 == 3'b001) begin
          bad = (funct7 != 7'b0);
        end else if (funct3 == 3'b101) begin
          bad = (funct7 != 7'b0) && (funct7 != 7'b010_0000);
        end
      end
      `RV_OPCODE_OP: begin
        rs1_en = 1'b1;
        rs2_en = 1'b1;
        case ({funct7, funct3})
          {7'b000_0000, 3'b000},
          {7'b010_0000, 3'b000},
          {7'b000_0000, 3'b001},
          {7'b000_0000, 3'b010},
          {7'b000_0000, 3'b011},
          {7'b000_0000, 3'b100},
          {7'b000_0000, 3'b101},
          {7'b010_0000, 3'b101},
          {7'b000_0000, 3'b110},
          {7'b000_0000, 3'b111}: bad = 1'b0;
          default:               bad = 1'b1;
        endcase
      end
      `RV_OPCODE_FENCE: begin
        // fence and fence.i only
        bad = (funct3 > 3'b001);
      end
      `RV_OPCODE_SYSTEM: begin
        // CSR forms are not supported
        if ((funct3 != 3'b000) || (rs1 != 5'd0) || (rd != 5'd0)) begin
          bad = 1'b1;
        end else begin
          case (funct12)
            12'h000, 12'h001, 12'h105, 12'h302: bad = 1'b0;
            `RV_DRET_FUNCT12:                   bad = !debug_mode_i;
            default:                            bad = 1'b1;
          endcase
        end
      end
      default: bad = 1'b1;
    endcase
  end

  // an illegal result claims both read ports
  assign illegal_o  = exp_i.illegal | bad;
  assign rs1_used_o = illegal_o | rs1_en;
  assign rs2_used_o = illegal_o | rs2_en;

endmodule

`default_nettype wire

// File: logic/rv_decode_consts.svh
////////////////////////////////////////
// opcodes, field widths and fixed encodings
// for the RV32 pre-decode stage
////////////////////////////////////////
`ifndef RV_DECODE_CONSTS_SVH
`define RV_DECODE_CONSTS_SVH

// widths
`define RV_INSTR_W   32
`define RV_CINSTR_W  16
`define RV_REG_W     5
`define RV_OPCODE_W  7
`define RV_FUNCT3_W  3
`define RV_FUNCT7_W  7

// major opcodes
`define RV_OPCODE_LOAD    7'h03
`define RV_OPCODE_FENCE   7'h0f
`define RV_OPCODE_OPIMM   7'h13
`define RV_OPCODE_AUIPC   7'h17
`define RV_OPCODE_STORE   7'h23
`define RV_OPCODE_OP      7'h33
`define RV_OPCODE_LUI     7'h37
`define RV_OPCODE_BRANCH  7'h63
`define RV_OPCODE_JALR    7'h67
`define RV_OPCODE_JAL     7'h6f
`define RV_OPCODE_SYSTEM  7'h73

// stack pointer and fixed encodings
`define RV_REG_SP        5'd2
`define RV_EBREAK_WORD   32'h0010_0073
`define RV_DRET_FUNCT12  12'h7b2

`endif

// File: logic/rv_isa_pkg.sv
////////////////////////////////////////
// instruction set field types
////////////////////////////////////////
`default_nettype none

`include "rv_decode_consts.svh"

package rv_isa_pkg;

  // full and compressed instruction words
  typedef logic [`RV_INSTR_W-1:0]  instr_t;
  typedef logic [`RV_CINSTR_W-1:0] cinstr_t;

  // instruction fields
  typedef logic [`RV_OPCODE_W-1:0] opcode_t;
  typedef logic [`RV_REG_W-1:0]    reg_idx_t;
  typedef logic [`RV_FUNCT3_W-1:0] funct3_t;
  typedef logic [`RV_FUNCT7_W-1:0] funct7_t;

  // low two bits, 2'b11 marks a 32-bit word
  typedef logic [1:0]              quadrant_t;

endpackage

`default_nettype wire

// File: logic/rv_predecode_top.sv
////////////////////////////////////////
// registered RV32 pre-decode stage
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module rv_predecode_top (
  input  wire logic                      clk_i,
  input  wire logic                      rst_n_i,
  input  wire logic                      instr_valid_i,
  input  wire rv_isa_pkg::instr_t        instr_i,
  input  wire logic                      debug_mode_i,
  output predecode_pkg::decode_result_t  result_o,
  output logic                           result_valid_o
);

  predecode_pkg::fetch_word_t fetch_w;
  predecode_pkg::expand_t     exp_w;
  logic                       illegal_w;
  logic                       rs1_used_w;
  logic                       rs2_used_w;

  fetch_capture u_fetch_capture (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .debug_mode_i  (debug_mode_i),
    .fetch_o       (fetch_w)
  );

  c_expander u_c_expander (
    .fetch_i (fetch_w),
    .exp_o   (exp_w)
  );

  rv32_legality_check u_rv32_legality_check (
    .exp_i        (exp_w),
    .debug_mode_i (fetch_w.debug_mode),
    .illegal_o    (illegal_w),
    .rs1_used_o   (rs1_used_w),
    .rs2_used_o   (rs2_used_w)
  );

  decode_result_reg u_decode_result_reg (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .valid_i        (fetch_w.valid),
    .exp_i          (exp_w),
    .illegal_i      (illegal_w),
    .rs1_used_i     (rs1_used_w),
    .rs2_used_i     (rs2_used_w),
    .result_o       (result_o),
    .result_valid_o (result_valid_o)
  );

endmodule

`default_nettype wire

// File: tests/tb_predecode_vectors.svh
////////////////////////////////////////
// decode vectors, hand-encoded from the
// RV32I and RVC encoding rules
////////////////////////////////////////
`ifndef TB_PREDECODE_VECTORS_SVH
`define TB_PREDECODE_VECTORS_SVH

// columns: input word, debug mode, expected word,
// compressed, illegal, rs1 used, rs2 used
task automatic load_vectors();
  // quadrant 0
  add_vector(32'h0000_0804, 1'b0, 32'h0101_0493, 1'b1, 1'b0, 1'b1, 1'b0); // c.addi4spn
  add_vector(32'h0000_41c8, 1'b0, 32'h0045_a503, 1'b1, 1'b0, 1'b1, 1'b0); // c.lw
  add_vector(32'h0000_c588, 1'b0, 32'h00a5_a423, 1'b1, 1'b0, 1'b1, 1'b1); // c.sw
  // quadrant 1
  add_vector(32'h0000_12f5, 1'b0, 32'hffd2_8293, 1'b1, 1'b0, 1'b1, 1'b0); // c.addi
  add_vector(32'h0000_2021, 1'b0, 32'h0080_00ef, 1'b1, 1'b0, 1'b0, 1'b0); // c.jal
  add_vector(32'h0000_431d, 1'b0, 32'h0070_0313, 1'b1, 1'b0, 1'b1, 1'b0); // c.li
  add_vector(32'h0000_6385, 1'b0, 32'h0000_13b7, 1'b1, 1'b0, 1'b0, 1'b0); // c.lui
  add_vector(32'h0000_713d, 1'b0, 32'hfe01_0113, 1'b1, 1'b0, 1'b1, 1'b0); // c.addi16sp
  add_vector(32'h0000_840d, 1'b0, 32'h4034_5413, 1'b1, 1'b0, 1'b1, 1'b0); // c.srai
  add_vector(32'h0000_98fd, 1'b0, 32'hfff4_f493, 1'b1, 1'b0, 1'b1, 1'b0); // c.andi
  add_vector(32'h0000_8c05, 1'b0, 32'h4094_0433, 1'b1, 1'b0, 1'b1, 1'b1); // c.sub
  add_vector(32'h0000_c111, 1'b0, 32'h0005_0263, 1'b1, 1'b0, 1'b1, 1'b1); // c.beqz
  // quadrant 2
  add_vector(32'h0000_0592, 1'b0, 32'h0045_9593, 1'b1, 1'b0, 1'b1, 1'b0); // c.slli
  add_vector(32'h0000_4622, 1'b0, 32'h0081_2603, 1'b1, 1'b0, 1'b1, 1'b0); // c.lwsp
  add_vector(32'h0000_8082, 1'b0, 32'h0000_8067, 1'b1, 1'b0, 1'b1, 1'b0); // c.jr
  add_vector(32'h0000_86ba, 1'b0, 32'h00e0_06b3, 1'b1, 1'b0, 1'b1, 1'b1); // c.mv
  add_vector(32'h0000_9282, 1'b0, 32'h0002_80e7, 1'b1, 1'b0, 1'b1, 1'b0); // c.jalr
  add_vector(32'h0000_9426, 1'b0, 32'h0094_0433, 1'b1, 1'b0, 1'b1, 1'b1); // c.add
  add_vector(32'h0000_9002, 1'b0, 32'h0010_0073, 1'b1, 1'b0, 1'b0, 1'b0); // c.ebreak
  add_vector(32'h0000_c63e, 1'b0, 32'h00f1_2623, 1'b1, 1'b0, 1'b1, 1'b1); // c.swsp
  // reserved compressed encodings, expanded word not checked
  add_vector(32'h0000_0000, 1'b0, 32'h0000_0000, 1'b1, 1'b1, 1'b1, 1'b1); // all zero
  add_vector(32'h0000_6000, 1'b0, 32'h0000_0000, 1'b1, 1'b1, 1'b1, 1'b1); // c.flw
  add_vector(32'h0000_4002, 1'b0, 32'h0000_0000, 1'b1, 1'b1, 1'b1, 1'b1); // c.lwsp x0
  add_vector(32'h0000_8002, 1'b0, 32'h0000_0000, 1'b1, 1'b1, 1'b1, 1'b1); // c.jr x0
  add_vector(32'h0000_6101, 1'b0, 32'h0000_0000, 1'b1, 1'b1, 1'b1, 1'b1); // c.addi16sp 0
  // full-width words pass through
  add_vector(32'hffdf_f06f, 1'b0, 32'hffdf_f06f, 1'b0, 1'b0, 1'b0, 1'b0); // j -4
  add_vector(32'h0003_2283, 1'b0, 32'h0003_2283, 1'b0, 1'b0, 1'b1, 1'b0); // lw
  add_vector(32'h0094_43b3, 1'b0, 32'h0094_43b3, 1'b0, 1'b0, 1'b1, 1'b1); // xor
  add_vector(32'h0ff0_000f, 1'b0, 32'h0ff0_000f, 1'b0, 1'b0, 1'b0, 1'b0); // fence
  add_vector(32'h0003_3283, 1'b0, 32'h0003_3283, 1'b0, 1'b1, 1'b1, 1'b1); // ld
  add_vector(32'h0294_03b3, 1'b0, 32'h0294_03b3, 1'b0, 1'b1, 1'b1, 1'b1); // mul
  add_vector(32'h3000_9073, 1'b0, 32'h3000_9073, 1'b0, 1'b1, 1'b1, 1'b1); // csrrw
  // dret depends on the captured debug mode, mret does not
  add_vector(32'h7b20_0073, 1'b0, 32'h7b20_0073, 1'b0, 1'b1, 1'b1, 1'b1);
  add_vector(32'h7b20_0073, 1'b1, 32'h7b20_0073, 1'b0, 1'b0, 1'b0, 1'b0);
  add_vector(32'h3020_0073, 1'b0, 32'h3020_0073, 1'b0, 1'b0, 1'b0, 1'b0);
  add_vector(32'h3020_0073, 1'b1, 32'h3020_0073, 1'b0, 1'b0, 1'b0, 1'b0);
endtask

`endif

// File: tests/tb_rv_predecode.sv
////////////////////////////////////////
// testbench for the RV32 pre-decode stage
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_rv_predecode;

  // one table row
  typedef struct packed {
    rv_isa_pkg::instr_t instr;
    logic               debug_mode;
    rv_isa_pkg::instr_t exp_instr;
    logic               exp_compressed;
    logic               exp_illegal;
    logic               exp_rs1;
    logic               exp_rs2;
  } vector_t;

  logic                          clk;
  logic                          rst_n;
  logic                          instr_valid;
  rv_isa_pkg::instr_t            instr;
  logic                          debug_mode;
  predecode_pkg::decode_result_t result;
  logic                          result_valid;

  vector_t vectors[$];
  int      checks;
  int      errors;
  bit      timed_out;

  rv_predecode_top u_rv_predecode_top (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .debug_mode_i   (debug_mode),
    .result_o       (result),
    .result_valid_o (result_valid)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic add_vector(input rv_isa_pkg::instr_t in_word, input logic dbg,
                            input rv_isa_pkg::instr_t exp_word, input logic is_c,
                            input logic ill, input logic rs1, input logic rs2);
    vector_t row;
    row.instr          = in_word;
    row.debug_mode     = dbg;
    row.exp_instr      = exp_word;
    row.exp_compressed = is_c;
    row.exp_illegal    = ill;
    row.exp_rs1        = rs1;
    row.exp_rs2        = rs2;
    vectors.push_back(row);
  endtask

  `include "tb_predecode_vectors.svh"

  task automatic compare_instr(input string name, input rv_isa_pkg::instr_t got,
                               input rv_isa_pkg::instr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_result(input int idx, input vector_t row);
    // a reserved encoding has no defined expansion
    if (!(row.exp_illegal && row.exp_compressed)) begin
      compare_instr($sformatf("row %0d result_o.instr", idx), result.instr, row.exp_instr);
    end
    compare_flag($sformatf("row %0d result_o.is_compressed", idx), result.is_compressed,
                 row.exp_compressed);
    compare_flag($sformatf("row %0d result_o.illegal", idx), result.illegal, row.exp_illegal);
    compare_flag($sformatf("row %0d result_o.rs1_used", idx), result.rs1_used, row.exp_rs1);
    compare_flag($sformatf("row %0d result_o.rs2_used", idx), result.rs2_used, row.exp_rs2);
  endtask

  task automatic drive_row(input vector_t row);
    instr_valid = 1'b1;
    instr       = row.instr;
    debug_mode  = row.debug_mode;
  endtask

  task automatic drive_idle();
    instr_valid = 1'b0;
    instr       = '0;
    debug_mode  = 1'b0;
  endtask

  // one row alone, then wait for its valid pulse
  task automatic run_single(input int idx, output bit ok);
    vector_t row;
    int      wait_cycles;
    row = vectors[idx];
    ok  = 1'b0;
    @(negedge clk);
    drive_row(row);
    @(negedge clk);
    drive_idle();
    wait_cycles = 1;
    while (!result_valid && wait_cycles < 10) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (!result_valid) begin
      errors++;
      $display("timeout: row %0d gave no result_valid_o within 10 cycles", idx);
    end else begin
      ok = 1'b1;
      checks++;
      if (wait_cycles != 2) begin
        errors++;
        $display("row %0d: result came %0d cycles after its input, not 2", idx, wait_cycles);
      end
      check_result(idx, row);
      // valid pulses once, data is held
      @(negedge clk);
      compare_flag($sformatf("row %0d result_valid_o after pulse", idx), result_valid, 1'b0);
      check_result(idx, row);
    end
  endtask

  // rows on consecutive cycles, each result two cycles later
  task automatic run_burst();
    vector_t row;
    int      n;
    n = vectors.size();
    for (int k = 0; k < n + 2; k++) begin
      @(negedge clk);
      if (k >= 2) begin
        row = vectors[k - 2];
        compare_flag($sformatf("burst row %0d result_valid_o", k - 2), result_valid, 1'b1);
        check_result(k - 2, row);
      end
      if (k < n) begin
        row = vectors[k];
        drive_row(row);
      end else begin
        drive_idle();
      end
    end
    @(negedge clk);
    compare_flag("result_valid_o after burst", result_valid, 1'b0);
  endtask

  initial begin
    bit ok;
    checks    = 0;
    errors    = 0;
    timed_out = 1'b0;
    rst_n     = 1'b0;
    drive_idle();
    load_vectors();

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // idle after reset
    repeat (3) begin
      @(negedge clk);
      compare_flag("result_valid_o idle", result_valid, 1'b0);
      compare_instr("result_o.instr idle", result.instr, '0);
      compare_flag("result_o.is_compressed idle", result.is_compressed, 1'b0);
      compare_flag("result_o.illegal idle", result.illegal, 1'b0);
      compare_flag("result_o.rs1_used idle", result.rs1_used, 1'b0);
      compare_flag("result_o.rs2_used idle", result.rs2_used, 1'b0);
    end

    for (int i = 0; i < vectors.size(); i++) begin
      run_single(i, ok);
      if (!ok) begin
        timed_out = 1'b1;
        break;
      end
    end
    if (!timed_out) begin
      run_burst();
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
